// File: hdl/can_rx_mailbox.sv
// Receive mailbox of one CAN channel
// Keeps the latest word, a pending flag for readout and an overrun flag
// when a waiting word gets overwritten

module can_rx_mailbox
   import mopshub_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      rx_valid,
   input  can_word_t rx_data,
   input  logic      grant,
   output logic      pending,
   output rx_entry_t entry
);

   can_word_t word_q;
   logic      pending_q;
   logic      overrun_q;

   // Pending and overrun tracking
   always_ff @(posedge clock) begin
      if (reset) begin
         pending_q <= 1'b0;
         overrun_q <= 1'b0;
      end else begin
         if (rx_valid) begin
            pending_q <= 1'b1;
            // Lost data only if the old word was not read out this cycle
            overrun_q <= pending_q & ~grant;
         end else if (grant) begin
            pending_q <= 1'b0;
            overrun_q <= 1'b0;
         end
      end
   end

   // Data storage
   always_ff @(posedge clock) begin
      if (rx_valid) begin
         word_q <= rx_data;
      end
   end

   assign pending       = pending_q;
   assign entry.data    = word_q;
   assign entry.overrun = overrun_q;

endmodule

// File: hdl/mopshub_pkg.sv
// Shared types for the hub receive readout path
// Word, mailbox entry and uplink frame layouts plus channel limits

package mopshub_pkg;

   // Channel limits
   localparam int MAX_CHANNELS = 32;
   localparam int CHANNEL_ID_W = $clog2(MAX_CHANNELS);

   localparam int CAN_WORD_W = 16;

   // One received data word from a channel controller
   typedef logic [CAN_WORD_W-1:0] can_word_t;

   // Channel number, wide enough for the largest hub
   typedef logic [CHANNEL_ID_W-1:0] channel_id_t;

   // What a mailbox offers the shared readout bus
   typedef struct packed {
      can_word_t data;
      logic      overrun;
   } rx_entry_t;

   // One frame towards the uplink
   // Parity is even over data only
   typedef struct packed {
      channel_id_t channel;
      can_word_t   data;
      logic        overrun;
      logic        parity;
   } uplink_frame_t;

   // Even parity bit for a data word
   function automatic logic even_parity(input can_word_t word);
      return ^word;
   endfunction

endpackage

// File: hdl/mopshub_readout_top.sv
// Receive readout path of the CAN hub
// Per-channel mailboxes share one readout bus through the arbiter,
// and granted words leave as uplink frames

module mopshub_readout_top
   import mopshub_pkg::*;
#(
   parameter int N_CHANNELS = MAX_CHANNELS
) (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [N_CHANNELS-1:0] rx_valid,
   input  can_word_t             rx_data [N_CHANNELS],
   input  logic                  choose_bus_start,
   output channel_id_t           bus_rec_select,
   output can_word_t             readdata,
   output logic                  irq_can_rec,
   output logic                  choose_bus_end,
   output uplink_frame_t         frame,
   output logic                  frame_valid
);

   logic [N_CHANNELS-1:0] can_rec;
   logic [N_CHANNELS-1:0] grant;
   rx_entry_t             entries [N_CHANNELS];
   rx_entry_t             granted_entry;

   // One mailbox per channel
   for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_mailbox
      can_rx_mailbox i_mailbox (
         .clock    (clock),
         .reset    (reset),
         .rx_valid (rx_valid[ch]),
         .rx_data  (rx_data[ch]),
         .grant    (grant[ch]),
         .pending  (can_rec[ch]),
         .entry    (entries[ch])
      );
   end

   node_readdata_decoder #(
      .N_CHANNELS (N_CHANNELS)
   ) i_decoder (
      .clock            (clock),
      .reset            (reset),
      .choose_bus_start (choose_bus_start),
      .can_rec          (can_rec),
      .entries          (entries),
      .grant            (grant),
      .bus_rec_select   (bus_rec_select),
      .readdata         (readdata),
      .granted_entry    (granted_entry),
      .irq_can_rec      (irq_can_rec),
      .choose_bus_end   (choose_bus_end)
   );

   uplink_frame_packer i_packer (
      .clock          (clock),
      .reset          (reset),
      .irq_can_rec    (irq_can_rec),
      .bus_rec_select (bus_rec_select),
      .granted_entry  (granted_entry),
      .frame          (frame),
      .frame_valid    (frame_valid)
   );

endmodule

// File: hdl/node_readdata_decoder.sv
// Readout bus arbiter for the channel mailboxes
// Grants the shared bus to the lowest pending channel on each start strobe
// and answers every request with choose_bus_end one cycle later

module node_readdata_decoder
   import mopshub_pkg::*;
#(
   parameter int N_CHANNELS = MAX_CHANNELS
) (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  choose_bus_start,
   input  logic [N_CHANNELS-1:0] can_rec,
   input  rx_entry_t             entries [N_CHANNELS],
   output logic [N_CHANNELS-1:0] grant,
   output channel_id_t           bus_rec_select,
   output can_word_t             readdata,
   output rx_entry_t             granted_entry,
   output logic                  irq_can_rec,
   output logic                  choose_bus_end
);

   logic [N_CHANNELS-1:0] request;
   logic                  win_found;
   channel_id_t           win_idx;
   logic [N_CHANNELS-1:0] win_onehot;
   logic                  transfer;

   // A mailbox granted last cycle still shows pending until this edge
   assign request = can_rec & ~grant;

   // Lowest set bit of request, as one-hot
   assign win_onehot = request & (~request + 1'b1);
   assign win_found  = |request;
   assign transfer   = choose_bus_start & win_found;

   // Priority encoder, scanning down so the lowest index is kept
   always_comb begin
      win_idx = '0;
      for (int i = N_CHANNELS - 1; i >= 0; i--) begin
         if (request[i]) begin
            win_idx = channel_id_t'(i);
         end
      end
   end

   // Request handshake and grant strobe
   always_ff @(posedge clock) begin
      if (reset) begin
         choose_bus_end <= 1'b0;
         irq_can_rec    <= 1'b0;
         grant          <= '0;
      end else begin
         choose_bus_end <= choose_bus_start;
         irq_can_rec    <= transfer;
         grant          <= transfer ? win_onehot : '0;
      end
   end

   // Bus contents, held until the next transfer
   always_ff @(posedge clock) begin
      if (reset) begin
         bus_rec_select <= '0;
         readdata       <= '0;
         granted_entry  <= '0;
      end else if (transfer) begin
         bus_rec_select <= win_idx;
         readdata       <= entries[win_idx].data;
         granted_entry  <= entries[win_idx];
      end
   end

endmodule

// File: hdl/uplink_frame_packer.sv
// Uplink frame packer
// Turns each granted readout word into a frame with channel number,
// overrun flag and even parity

module uplink_frame_packer
   import mopshub_pkg::*;
(
   input  logic          clock,
   input  logic          reset,
   input  logic          irq_can_rec,
   input  channel_id_t   bus_rec_select,
   input  rx_entry_t     granted_entry,
   output uplink_frame_t frame,
   output logic          frame_valid
);

   uplink_frame_t next_frame;

   // Frame fields from the current bus contents
   always_comb begin
      next_frame.channel = bus_rec_select;
      next_frame.data    = granted_entry.data;
      next_frame.overrun = granted_entry.overrun;
      next_frame.parity  = even_parity(granted_entry.data);
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         frame_valid <= 1'b0;
      end else begin
         frame_valid <= irq_can_rec;
      end
   end

   // Frame stays after the strobe until the next transfer
   always_ff @(posedge clock) begin
      if (reset) begin
         frame <= '0;
      end else if (irq_can_rec) begin
         frame <= next_frame;
      end
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the readout testbench with Verilator and run it.
# Exit status is 0 only when the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f \
   --top-module tb_mopshub_readout -o tb_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// File: verif/tb_mopshub_readout.sv
// Testbench for the hub receive readout path
// Table-driven stimulus against a cycle model of mailboxes, arbiter and packer

module tb_mopshub_readout
   import mopshub_pkg::*;
();

   localparam int N_CHANNELS = 32;

   // One stimulus row, followed by idle cycles
   typedef struct packed {
      logic [N_CHANNELS-1:0] mask;
      logic                  rand_data;
      can_word_t             data;
      logic                  start;
      logic [7:0]            idle;
   } stim_row_t;

   logic                  clock = 1'b0;
   logic                  reset;
   logic [N_CHANNELS-1:0] rx_valid;
   can_word_t             rx_data [N_CHANNELS];
   logic                  choose_bus_start;
   channel_id_t           bus_rec_select;
   can_word_t             readdata;
   logic                  irq_can_rec;
   logic                  choose_bus_end;
   uplink_frame_t         frame;
   logic                  frame_valid;

   stim_row_t             rows [$];
   logic [31:0]           rng_state;

   // Reference model state
   logic [N_CHANNELS-1:0] m_pend;
   logic [N_CHANNELS-1:0] m_ovr;
   can_word_t             m_word [N_CHANNELS];
   logic [N_CHANNELS-1:0] m_grant;
   logic                  m_end;
   logic                  m_irq;
   channel_id_t           m_sel;
   can_word_t             m_data;
   rx_entry_t             m_gent;
   logic                  m_fvalid;
   uplink_frame_t         m_frame;

   int                    check_count = 0;
   int                    select_errors = 0;
   int                    flag_errors = 0;
   int                    frame_errors = 0;
   int                    frames_seen = 0;

   mopshub_readout_top #(
      .N_CHANNELS (N_CHANNELS)
   ) i_dut (
      .clock            (clock),
      .reset            (reset),
      .rx_valid         (rx_valid),
      .rx_data          (rx_data),
      .choose_bus_start (choose_bus_start),
      .bus_rec_select   (bus_rec_select),
      .readdata         (readdata),
      .irq_can_rec      (irq_can_rec),
      .choose_bus_end   (choose_bus_end),
      .frame            (frame),
      .frame_valid      (frame_valid)
   );

   always #4 clock = ~clock;

   // xorshift32
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic data_parity(input can_word_t w);
      logic p;
      p = 1'b0;
      for (int i = 0; i < 16; i++) begin
         p = p ^ w[i];
      end
      return p;
   endfunction

   task automatic add_row(input logic [N_CHANNELS-1:0] mask, input logic rand_data,
                          input can_word_t data, input logic start, input int idle);
      stim_row_t r;
      r.mask      = mask;
      r.rand_data = rand_data;
      r.data      = data;
      r.start     = start;
      r.idle      = 8'(idle);
      rows.push_back(r);
   endtask

   task automatic build_table();
      // Request with nothing received
      add_row('0, 1'b0, 16'h0000, 1'b1, 4);
      // Priority, high and low channels at once
      add_row(32'hC000_0025, 1'b0, 16'h1200, 1'b0, 1);
      repeat (6) add_row('0, 1'b0, 16'h0000, 1'b1, 3);
      // Random frame contents
      add_row(32'h0300_F00F, 1'b1, 16'h0000, 1'b0, 1);
      repeat (11) add_row('0, 1'b0, 16'h0000, 1'b1, 2);
      // Overrun on channel 7, then a clean word
      add_row(32'h0000_0080, 1'b0, 16'hA5A5, 1'b0, 1);
      add_row(32'h0000_0080, 1'b0, 16'h5A5A, 1'b0, 1);
      add_row('0, 1'b0, 16'h0000, 1'b1, 3);
      add_row(32'h0000_0080, 1'b0, 16'h0F0F, 1'b0, 1);
      add_row('0, 1'b0, 16'h0000, 1'b1, 3);
      // Write to channel 9 in its grant cycle
      add_row(32'h0000_0200, 1'b0, 16'h1111, 1'b0, 1);
      add_row('0, 1'b0, 16'h0000, 1'b1, 0);
      add_row(32'h0000_0200, 1'b0, 16'h2222, 1'b0, 3);
      add_row('0, 1'b0, 16'h0000, 1'b1, 3);
      add_row('0, 1'b0, 16'h0000, 1'b1, 3);
      // Back-to-back starts with two frames in flight
      add_row(32'h0010_1008, 1'b1, 16'h0000, 1'b0, 1);
      repeat (4) add_row('0, 1'b0, 16'h0000, 1'b1, 0);
      repeat (3) add_row('0, 1'b0, 16'h0000, 1'b1, 3);
   endtask

   task automatic reset_model();
      m_pend   = '0;
      m_ovr    = '0;
      m_grant  = '0;
      m_end    = 1'b0;
      m_irq    = 1'b0;
      m_sel    = '0;
      m_data   = '0;
      m_gent   = '0;
      m_fvalid = 1'b0;
      m_frame  = '0;
      for (int ch = 0; ch < N_CHANNELS; ch++) begin
         m_word[ch] = '0;
      end
   endtask

   // Advance the model by one rising edge with the inputs now driven
   task automatic step_model();
      logic [N_CHANNELS-1:0] old_pend;
      logic [N_CHANNELS-1:0] old_grant;
      logic                  old_irq;
      channel_id_t           old_sel;
      rx_entry_t             old_gent;
      logic                  found;
      int                    win;
      old_pend  = m_pend;
      old_grant = m_grant;
      old_irq   = m_irq;
      old_sel   = m_sel;
      old_gent  = m_gent;

      // Packer
      m_fvalid = old_irq;
      if (old_irq) begin
         m_frame.channel = old_sel;
         m_frame.data    = old_gent.data;
         m_frame.overrun = old_gent.overrun;
         m_frame.parity  = data_parity(old_gent.data);
      end

      // Arbiter, lowest pending channel wins
      // A channel read out on the previous start is already taken
      found = 1'b0;
      win   = 0;
      for (int i = 0; i < N_CHANNELS; i++) begin
         if (!found && old_pend[i] && !old_grant[i]) begin
            found = 1'b1;
            win   = i;
         end
      end
      m_end   = choose_bus_start;
      m_irq   = choose_bus_start & found;
      m_grant = '0;
      if (choose_bus_start && found) begin
         m_grant[win]   = 1'b1;
         m_sel          = channel_id_t'(win);
         m_data         = m_word[win];
         m_gent.data    = m_word[win];
         m_gent.overrun = m_ovr[win];
      end

      // Mailboxes see the grant from the previous edge
      for (int ch = 0; ch < N_CHANNELS; ch++) begin
         if (rx_valid[ch]) begin
            m_ovr[ch]  = old_pend[ch] & ~old_grant[ch];
            m_pend[ch] = 1'b1;
            m_word[ch] = rx_data[ch];
         end else if (old_grant[ch]) begin
            m_pend[ch] = 1'b0;
            m_ovr[ch]  = 1'b0;
         end
      end
   endtask

   task automatic check_select(input channel_id_t exp_sel, input can_word_t exp_data);
      check_count++;
      if (bus_rec_select !== exp_sel || readdata !== exp_data) begin
         select_errors++;
         $display("ERR @%0t: bus select %0d data %h, expected select %0d data %h",
                  $time, bus_rec_select, readdata, exp_sel, exp_data);
      end
   endtask

   task automatic check_flags(input logic exp_irq, input logic exp_end);
      check_count++;
      if (irq_can_rec !== exp_irq || choose_bus_end !== exp_end) begin
         flag_errors++;
         $display("ERR @%0t: irq %b end %b, expected irq %b end %b",
                  $time, irq_can_rec, choose_bus_end, exp_irq, exp_end);
      end
   endtask

   task automatic check_frame(input logic exp_valid, input uplink_frame_t exp_frame);
      check_count++;
      if (frame_valid !== exp_valid || frame !== exp_frame) begin
         frame_errors++;
         $display("ERR @%0t: frame valid %b ch %0d data %h ovr %b par %b, expected %b %0d %h %b %b",
                  $time, frame_valid, frame.channel, frame.data, frame.overrun, frame.parity,
                  exp_valid, exp_frame.channel, exp_frame.data, exp_frame.overrun,
                  exp_frame.parity);
      end
      if (frame_valid === 1'b1) begin
         frames_seen++;
      end
   endtask

   task automatic check_outputs();
      check_flags(m_irq, m_end);
      check_select(m_sel, m_data);
      check_frame(m_fvalid, m_frame);
   endtask

   // Drive one cycle at the falling edge, check at the next one
   task automatic apply_cycle(input logic [N_CHANNELS-1:0] mask, input logic rand_data,
                              input can_word_t data, input logic start);
      logic [31:0] r;
      for (int ch = 0; ch < N_CHANNELS; ch++) begin
         r = next_random();
         rx_data[ch] = rand_data ? r[15:0] : (data ^ can_word_t'(ch));
      end
      rx_valid         = mask;
      choose_bus_start = start;
      step_model();
      @(negedge clock);
      check_outputs();
   endtask

   task automatic watchdog(input int cycles);
      #(cycles * 16);
      $display("Simulation timed out after %0d cycles without finishing the table", cycles * 2);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   initial begin
      int limit_cycles;
      reset            = 1'b1;
      rx_valid         = '0;
      choose_bus_start = 1'b0;
      for (int ch = 0; ch < N_CHANNELS; ch++) begin
         rx_data[ch] = '0;
      end
      rng_state = 32'd62;
      build_table();
      reset_model();

      limit_cycles = 0;
      foreach (rows[i]) begin
         limit_cycles += 1 + int'(rows[i].idle) + 4;
      end
      fork
         watchdog(limit_cycles);
      join_none

      repeat (5) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      check_outputs();

      foreach (rows[i]) begin
         apply_cycle(rows[i].mask, rows[i].rand_data, rows[i].data, rows[i].start);
         repeat (int'(rows[i].idle)) apply_cycle('0, 1'b0, 16'h0000, 1'b0);
      end
      repeat (4) apply_cycle('0, 1'b0, 16'h0000, 1'b0);

      $display("Checks %0d, errors %0d (select %0d, flags %0d, frame %0d), frames seen %0d",
               check_count, select_errors + flag_errors + frame_errors,
               select_errors, flag_errors, frame_errors, frames_seen);
      if (select_errors + flag_errors + frame_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: vlog.f
hdl/mopshub_pkg.sv
hdl/can_rx_mailbox.sv
hdl/node_readdata_decoder.sv
hdl/uplink_frame_packer.sv
hdl/mopshub_readout_top.sv
verif/tb_mopshub_readout.sv
